//--- design/pe_array_config.svh
`ifndef PE_ARRAY_CONFIG_SVH
`define PE_ARRAY_CONFIG_SVH

// Operand width of weights and activations
`define PA_DATA_WIDTH 16

// Accumulator and result width
`define PA_ACC_WIDTH 40

// Columns in one row
`define PA_NUM_COL 4

// Command queue entries
`define PA_FIFO_DEPTH 8

`endif

//--- design/pe_array_pkg.sv
`default_nettype none
`include "pe_array_config.svh"

package pe_array_pkg;

    //////////////////////////////////////////////////
    // Width types
    //////////////////////////////////////////////////

    // One operand word
    typedef logic signed [`PA_DATA_WIDTH-1:0] data_t;

    // Accumulator and row result
    typedef logic signed [`PA_ACC_WIDTH-1:0] acc_t;

    // Column tag, one value per column
    typedef logic [$clog2(`PA_NUM_COL)-1:0] tag_t;

    // Command opcode
    typedef logic [1:0] op_t;

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////

    localparam op_t OP_LOAD_W = 2'd0;
    localparam op_t OP_MAC    = 2'd1;
    localparam op_t OP_READ   = 2'd2;

    // Broadcast command word
    typedef struct packed {
        op_t   op;
        tag_t  tag;
        data_t data;
    } bus_word_t;

endpackage

`default_nettype wire

//--- design/cmd_fifo.sv
`default_nettype none
`include "pe_array_config.svh"

module cmd_fifo import pe_array_pkg::*; (
    input  wire            clk,
    input  wire            rstn,
    input  wire            push,
    input  wire bus_word_t wr_word,
    input  wire            pop,
    output bus_word_t      head,
    output logic           not_empty,
    output logic           full
);

    localparam int DEPTH = `PA_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bus_word_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap a pointer at the last entry
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Push while full is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Occupancy follows push and pop together
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest entry
    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- design/cmd_dispatch.sv
`default_nettype none
`include "pe_array_config.svh"

module cmd_dispatch import pe_array_pkg::*; (
    input  wire            clk,
    input  wire            rstn,
    // Queue side
    input  wire bus_word_t head,
    input  wire            not_empty,
    output logic           pop,
    // Broadcast bus side
    output bus_word_t      bus_word,
    output logic           bus_en,
    input  wire            bus_ready,
    input  wire            col_valid,
    input  wire acc_t      col_data,
    // Row result
    output logic           res_valid,
    output acc_t           res_data
);

    //////////////////////////////////////////////////
    // Command issue
    //////////////////////////////////////////////////

    // Bus is valid whenever the queue holds a command
    assign bus_en = not_empty;

    // Head word goes to every caster as is
    assign bus_word = head;

    // Acceptance cycle
    // Matched column is ready while the head is on the bus
    assign pop = not_empty && bus_ready;

    //////////////////////////////////////////////////
    // Reply collection
    //////////////////////////////////////////////////

    // Valid lasts one cycle per collected reply
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= col_valid;
        end
    end

    // Column data is already zero when no column replies
    always_ff @(posedge clk) begin
        res_data <= col_data;
    end

endmodule

`default_nettype wire

//--- design/pe_caster.sv
`default_nettype none
`include "pe_array_config.svh"

module pe_caster import pe_array_pkg::*; (
    input  wire            clk,
    input  wire            rstn,
    // Tag shift chain
    input  wire            cfg_shift,
    input  wire tag_t      tag_in,
    output tag_t           tag_out,
    // Broadcast bus
    input  wire bus_word_t bus_word,
    input  wire            bus_en,
    output logic           hit_ready,
    output logic           hit_valid,
    output acc_t           hit_data,
    // PE side
    output logic           pe_en,
    output op_t            pe_op,
    output data_t          pe_data,
    input  wire            pe_ready,
    input  wire            pe_res_valid,
    input  wire acc_t      pe_res_data
);

    tag_t col_tag;
    logic key_match;
    logic read_hit;

    //////////////////////////////////////////////////
    // Column tag
    //////////////////////////////////////////////////

    // Shift register stage of the tag chain
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col_tag <= '0;
        end else if (cfg_shift) begin
            col_tag <= tag_in;
        end
    end

    assign tag_out = col_tag;

    //////////////////////////////////////////////////
    // Key and lock
    //////////////////////////////////////////////////

    // Lock opens on a valid bus word carrying this column's tag
    assign key_match = bus_en && (bus_word.tag == col_tag);
    assign hit_ready = key_match && pe_ready;
    assign pe_en     = key_match && pe_ready;

    // Operands reach the PE only through an open lock
    assign pe_op   = pe_en ? bus_word.op : '0;
    assign pe_data = pe_en ? bus_word.data : '0;

    // Remember a READ accepted here
    // A tag reshift before the reply must not redirect it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            read_hit <= 1'b0;
        end else begin
            read_hit <= pe_en && (bus_word.op == OP_READ);
        end
    end

    // Reply goes on the shared lines only for this column's READ
    assign hit_valid = pe_res_valid && read_hit;
    assign hit_data  = hit_valid ? pe_res_data : '0;

endmodule

`default_nettype wire

//--- design/pe_mac.sv
`default_nettype none
`include "pe_array_config.svh"

module pe_mac import pe_array_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    input  wire        en,
    input  wire op_t   op,
    input  wire data_t data,
    output logic       ready,
    output logic       res_valid,
    output acc_t       res_data
);

    data_t weight;
    acc_t  prod;
    logic  prod_pending;
    acc_t  acc;
    logic  accept_load;
    logic  accept_mac;
    logic  accept_read;

    // Busy for one cycle after a MAC
    assign ready = !prod_pending;

    // Decode accepted command
    assign accept_load = en && ready && (op == OP_LOAD_W);
    assign accept_mac  = en && ready && (op == OP_MAC);
    assign accept_read = en && ready && (op == OP_READ);

    //////////////////////////////////////////////////
    // Weight register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            weight <= '0;
        end else if (accept_load) begin
            weight <= data;
        end
    end

    //////////////////////////////////////////////////
    // Stage 1 product
    //////////////////////////////////////////////////

    // Signed operands extend to accumulator width
    always_ff @(posedge clk) begin
        if (accept_mac) begin
            prod <= data * weight;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod_pending <= 1'b0;
        end else begin
            prod_pending <= accept_mac;
        end
    end

    //////////////////////////////////////////////////
    // Stage 2 accumulate and read-and-clear
    //////////////////////////////////////////////////

    // Sum wraps at accumulator width
    // READ cannot arrive while a product is pending
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc <= '0;
        end else if (prod_pending) begin
            acc <= acc + prod;
        end else if (accept_read) begin
            acc <= '0;
        end
    end

    // Result pulse one cycle after READ acceptance
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= accept_read;
        end
    end

    // Accumulator value captured as it clears
    always_ff @(posedge clk) begin
        if (accept_read) begin
            res_data <= acc;
        end
    end

endmodule

`default_nettype wire

//--- design/pe_row.sv
`default_nettype none
`include "pe_array_config.svh"

module pe_row import pe_array_pkg::*; (
    input  wire            clk,
    input  wire            rstn,
    // Tag configuration
    input  wire            cfg_shift,
    input  wire tag_t      cfg_tag,
    // Host commands
    input  wire            cmd_push,
    input  wire bus_word_t cmd,
    output logic           cmd_full,
    // Row result
    output logic           res_valid,
    output acc_t           res_data
);

    localparam int NCOL = `PA_NUM_COL;

    bus_word_t       fifo_head;
    logic            fifo_not_empty;
    logic            fifo_pop;
    bus_word_t       bus_word;
    logic            bus_en;
    logic            bus_ready;
    logic            col_valid;
    acc_t            col_data;
    tag_t            tag_link [NCOL+1];
    logic [NCOL-1:0] hit_ready;
    logic [NCOL-1:0] hit_valid;
    acc_t            hit_data [NCOL];

    //////////////////////////////////////////////////
    // Queue and dispatcher
    //////////////////////////////////////////////////

    cmd_fifo u_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .push      (cmd_push),
        .wr_word   (cmd),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .not_empty (fifo_not_empty),
        .full      (cmd_full)
    );

    cmd_dispatch u_dispatch (
        .clk       (clk),
        .rstn      (rstn),
        .head      (fifo_head),
        .not_empty (fifo_not_empty),
        .pop       (fifo_pop),
        .bus_word  (bus_word),
        .bus_en    (bus_en),
        .bus_ready (bus_ready),
        .col_valid (col_valid),
        .col_data  (col_data),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    //////////////////////////////////////////////////
    // Columns
    //////////////////////////////////////////////////

    // Tag chain enters at column 0
    assign tag_link[0] = cfg_tag;

    for (genvar k = 0; k < NCOL; k++) begin : g_col
        logic  pe_en;
        op_t   pe_op;
        data_t pe_data;
        logic  pe_ready;
        logic  pe_res_valid;
        acc_t  pe_res_data;

        pe_caster u_caster (
            .clk          (clk),
            .rstn         (rstn),
            .cfg_shift    (cfg_shift),
            .tag_in       (tag_link[k]),
            .tag_out      (tag_link[k+1]),
            .bus_word     (bus_word),
            .bus_en       (bus_en),
            .hit_ready    (hit_ready[k]),
            .hit_valid    (hit_valid[k]),
            .hit_data     (hit_data[k]),
            .pe_en        (pe_en),
            .pe_op        (pe_op),
            .pe_data      (pe_data),
            .pe_ready     (pe_ready),
            .pe_res_valid (pe_res_valid),
            .pe_res_data  (pe_res_data)
        );

        pe_mac u_pe (
            .clk       (clk),
            .rstn      (rstn),
            .en        (pe_en),
            .op        (pe_op),
            .data      (pe_data),
            .ready     (pe_ready),
            .res_valid (pe_res_valid),
            .res_data  (pe_res_data)
        );
    end

    // Wired-OR of column replies
    // At most one lock is open per cycle
    assign bus_ready = |hit_ready;
    assign col_valid = |hit_valid;

    always_comb begin
        col_data = '0;
        for (int k = 0; k < NCOL; k++) begin
            col_data = col_data | hit_data[k];
        end
    end

endmodule

`default_nettype wire

//--- tests/pe_array_checker.sv
`default_nettype none
`include "pe_array_config.svh"

module pe_array_checker import pe_array_pkg::*; (
    input  wire            clk,
    input  wire            rstn,
    input  wire            cfg_shift,
    input  wire tag_t      cfg_tag,
    input  wire            cmd_push,
    input  wire bus_word_t cmd,
    input  wire            cmd_full,
    input  wire            res_valid,
    input  wire acc_t      res_data,
    output int             error_count,
    output int             pending,
    output int             result_count
);

    localparam int NCOL = `PA_NUM_COL;

    // Reference state per column
    tag_t  col_tag [NCOL];
    data_t weight  [NCOL];
    acc_t  acc     [NCOL];

    // Results owed to the host, oldest first
    acc_t  expected [$];

    //////////////////////////////////////////////////
    // Model helpers
    //////////////////////////////////////////////////

    // Lowest column holding the tag, -1 if none
    function automatic int column_of(input tag_t tag);
        int col;
        col = -1;
        for (int k = NCOL - 1; k >= 0; k--) begin
            if (col_tag[k] == tag) begin
                col = k;
            end
        end
        return col;
    endfunction

    task automatic clear_model();
        for (int k = 0; k < NCOL; k++) begin
            col_tag[k] = '0;
            weight[k]  = '0;
            acc[k]     = '0;
        end
        expected.delete();
    endtask

    // New tag enters column 0, the rest move one column up
    task automatic shift_tag(input tag_t tag_in);
        for (int k = NCOL - 1; k > 0; k--) begin
            col_tag[k] = col_tag[k-1];
        end
        col_tag[0] = tag_in;
    endtask

    // Commands take effect in queue order
    task automatic apply_cmd(input bus_word_t word);
        int col;
        col = column_of(word.tag);
        if (col < 0) begin
            $display("command sent to tag %0d, which no column holds", word.tag);
            error_count++;
            return;
        end
        case (word.op)
            OP_LOAD_W: weight[col] = word.data;
            // Sign-extended product, sum wraps at accumulator width
            OP_MAC:    acc[col] = acc[col] + acc_t'(weight[col]) * acc_t'(word.data);
            OP_READ: begin
                expected.push_back(acc[col]);
                acc[col] = '0;
            end
            default: begin
                $display("command with unknown opcode %0d was pushed", word.op);
                error_count++;
            end
        endcase
    endtask

    task automatic check_result(input acc_t value);
        acc_t want;
        result_count++;
        if (expected.size() == 0) begin
            $display("error %0t: result %0d with no READ outstanding", $time, value);
            error_count++;
        end else begin
            want = expected.pop_front();
            if (value !== want) begin
                $display("error %0t: result %0d, expected %0d", $time, value, want);
                error_count++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Sampling at the rising edge
    //////////////////////////////////////////////////

    initial begin
        error_count  = 0;
        pending      = 0;
        result_count = 0;
        clear_model();
    end

    // Full flag sampled here is the one the queue uses for this push
    always @(posedge clk) begin
        if (!rstn) begin
            clear_model();
        end else begin
            if (res_valid) begin
                check_result(res_data);
            end
            if (cfg_shift) begin
                shift_tag(cfg_tag);
            end
            if (cmd_push && !cmd_full) begin
                apply_cmd(cmd);
            end
        end
        pending = expected.size();
    end

endmodule

`default_nettype wire

//--- tests/tb_pe_array.sv
`default_nettype none
`include "pe_array_config.svh"

module tb_pe_array import pe_array_pkg::*; ();

    localparam int NCOL    = `PA_NUM_COL;
    localparam int DEPTH   = `PA_FIFO_DEPTH;
    localparam int TIMEOUT = 2000;
    localparam logic [31:0] SEED = 32'h1d4d1c55;

    logic      clk;
    logic      rstn;
    logic      cfg_shift;
    tag_t      cfg_tag;
    logic      cmd_push;
    bus_word_t cmd;
    logic      cmd_full;
    logic      res_valid;
    acc_t      res_data;

    // Checker outputs
    int        chk_errors;
    int        pending;
    int        results;

    int        tb_errors;
    int        errs_before;
    int        tests_run;
    int        tests_failed;
    logic      hung;
    tag_t      perm [NCOL];

    always #50 clk = ~clk;

    pe_row dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_shift (cfg_shift),
        .cfg_tag   (cfg_tag),
        .cmd_push  (cmd_push),
        .cmd       (cmd),
        .cmd_full  (cmd_full),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    pe_array_checker chk_i (
        .clk          (clk),
        .rstn         (rstn),
        .cfg_shift    (cfg_shift),
        .cfg_tag      (cfg_tag),
        .cmd_push     (cmd_push),
        .cmd          (cmd),
        .cmd_full     (cmd_full),
        .res_valid    (res_valid),
        .res_data     (res_data),
        .error_count  (chk_errors),
        .pending      (pending),
        .result_count (results)
    );

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("error %0t: %s", $time, msg);
        tb_errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        hung = 1'b1;
    endtask

    task automatic start_test();
        errs_before = chk_errors + tb_errors;
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        errs = chk_errors + tb_errors - errs_before;
        tests_run++;
        if (errs != 0 || hung) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errs);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
    endtask

    //////////////////////////////////////////////////
    // Host actions from a falling edge
    //////////////////////////////////////////////////

    task automatic apply_reset();
        rstn = 1'b0;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
    endtask

    // Holds off while the queue is full
    task automatic push_cmd(input op_t op, input tag_t tag, input data_t data);
        int n;
        if (hung) return;
        n = 0;
        while (cmd_full && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cmd_full) begin
            report_timeout("free queue entry");
            return;
        end
        cmd_push = 1'b1;
        cmd.op   = op;
        cmd.tag  = tag;
        cmd.data = data;
        @(negedge clk);
        cmd_push = 1'b0;
    endtask

    task automatic push_random();
        push_cmd(op_t'($urandom_range(2)), tag_t'($urandom_range(NCOL - 1)),
                 data_t'($urandom));
    endtask

    task automatic read_all();
        for (int t = 0; t < NCOL; t++) begin
            push_cmd(OP_READ, tag_t'(t), '0);
        end
    endtask

    // Until every owed result has come back
    task automatic drain();
        int n;
        if (hung) return;
        n = 0;
        while (pending != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (pending != 0) begin
            report_timeout("return of all expected results");
        end
    endtask

    // Fisher-Yates over the tag values
    task automatic shuffle_tags();
        int   j;
        tag_t tmp;
        for (int i = 0; i < NCOL; i++) begin
            perm[i] = tag_t'(i);
        end
        for (int i = NCOL - 1; i > 0; i--) begin
            j       = $urandom_range(i);
            tmp     = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
    endtask

    // Reshuffle until at least one column changes its tag
    task automatic shuffle_new_tags();
        tag_t old [NCOL];
        logic same;
        int   n;
        old  = perm;
        same = 1'b1;
        n    = 0;
        while (same && n < TIMEOUT) begin
            shuffle_tags();
            same = 1'b1;
            for (int k = 0; k < NCOL; k++) begin
                if (perm[k] != old[k]) begin
                    same = 1'b0;
                end
            end
            n++;
        end
    endtask

    // Shift j lands in column NCOL-1-j
    task automatic shift_tags();
        for (int j = 0; j < NCOL; j++) begin
            cfg_shift = 1'b1;
            cfg_tag   = perm[NCOL-1-j];
            @(negedge clk);
        end
        cfg_shift = 1'b0;
    endtask

    task automatic check_idle(input string when);
        if (res_valid !== 1'b0) begin
            report_mismatch($sformatf("res_valid high %s", when));
        end
        if (cmd_full !== 1'b0) begin
            report_mismatch($sformatf("cmd_full high %s", when));
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_tag_config();
        start_test();
        shuffle_tags();
        shift_tags();
        read_all();
        drain();
        finish_test(1, "tag config");
    endtask

    task automatic test_random_ops();
        start_test();
        for (int i = 0; i < 200; i++) begin
            push_random();
        end
        read_all();
        drain();
        finish_test(2, "random commands");
    endtask

    // Back-to-back MACs stall on the busy column
    task automatic test_mac_bursts();
        tag_t t;
        int   len;
        start_test();
        for (int b = 0; b < 6; b++) begin
            t   = tag_t'($urandom_range(NCOL - 1));
            len = 2 + $urandom_range(6);
            push_cmd(OP_LOAD_W, t, data_t'($urandom));
            for (int i = 0; i < len; i++) begin
                push_cmd(OP_MAC, t, data_t'($urandom));
            end
            push_cmd(OP_READ, t, '0);
        end
        drain();
        finish_test(3, "MAC bursts");
    endtask

    task automatic test_queue_full();
        tag_t t;
        int   occ;
        logic busy;
        logic pop;
        logic rose;
        int   n;
        start_test();
        t = tag_t'($urandom_range(NCOL - 1));
        push_cmd(OP_LOAD_W, t, data_t'($urandom));
        push_cmd(OP_READ, t, '0);
        drain();
        // Occupancy predicted for one MAC push per cycle into one column
        // The column takes one every second cycle
        occ  = 0;
        busy = 1'b0;
        rose = 1'b0;
        for (n = 0; n < TIMEOUT && !rose && !hung; n++) begin
            if (cmd_full !== (occ == DEPTH)) begin
                report_mismatch($sformatf("cmd_full %b with %0d entries queued",
                                          cmd_full, occ));
            end
            if (cmd_full) begin
                rose = 1'b1;
            end else begin
                cmd_push = 1'b1;
                cmd.op   = OP_MAC;
                cmd.tag  = t;
                cmd.data = data_t'($urandom);
                pop      = (occ > 0) && !busy;
                occ      = occ + 1 - int'(pop);
                busy     = pop;
                @(negedge clk);
            end
        end
        cmd_push = 1'b0;
        if (!rose && !hung) begin
            report_timeout("rise of cmd_full");
        end
        // One push against the full queue is dropped
        if (rose) begin
            cmd_push = 1'b1;
            cmd.data = data_t'($urandom);
            @(negedge clk);
            cmd_push = 1'b0;
        end
        push_cmd(OP_READ, t, '0);
        drain();
        finish_test(4, "queue full");
    endtask

    task automatic test_reshift();
        start_test();
        for (int t = 0; t < NCOL; t++) begin
            push_cmd(OP_LOAD_W, tag_t'(t), data_t'($urandom));
            push_cmd(OP_MAC, tag_t'(t), data_t'($urandom));
            push_cmd(OP_MAC, tag_t'(t), data_t'($urandom));
        end
        // Trailing READ marks the queue empty once it returns
        push_cmd(OP_READ, '0, '0);
        drain();
        shuffle_new_tags();
        shift_tags();
        for (int i = 0; i < 20; i++) begin
            push_random();
        end
        read_all();
        drain();
        finish_test(5, "reshift");
    endtask

    task automatic test_reset_midstream();
        tag_t t;
        int   n;
        start_test();
        t = tag_t'($urandom_range(NCOL - 1));
        push_cmd(OP_LOAD_W, t, data_t'($urandom));
        // MAC and READ alternate so the queue fills with results in flight
        n = 0;
        while (!cmd_full && n < TIMEOUT && !hung) begin
            if (n % 2 == 0) begin
                push_cmd(OP_MAC, t, data_t'($urandom));
            end else begin
                push_cmd(OP_READ, t, '0);
            end
            n++;
        end
        if (!cmd_full && !hung) begin
            report_timeout("rise of cmd_full before reset");
        end
        // Queue full here
        rstn = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_idle("during reset");
        end
        rstn = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        // Tags are all zero after reset
        shuffle_tags();
        shift_tags();
        read_all();
        drain();
        finish_test(6, "reset midstream");
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        rstn         = 1'b0;
        cfg_shift    = 1'b0;
        cfg_tag      = '0;
        cmd_push     = 1'b0;
        cmd          = '0;
        tb_errors    = 0;
        errs_before  = 0;
        tests_run    = 0;
        tests_failed = 0;
        hung         = 1'b0;
        apply_reset();
        @(negedge clk);
        test_tag_config();
        test_random_ops();
        test_mac_bursts();
        test_queue_full();
        test_reshift();
        test_reset_midstream();
        $display("%0d tests run, %0d failed, %0d errors, %0d results checked",
                 tests_run, tests_failed, chk_errors + tb_errors, results);
        if (hung || tests_failed != 0 || (chk_errors + tb_errors) != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/pe_array_pkg.sv
design/cmd_fifo.sv
design/cmd_dispatch.sv
design/pe_caster.sv
design/pe_mac.sv
design/pe_row.sv
tests/pe_array_checker.sv
tests/tb_pe_array.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pe_row testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_pe_array
log_file=sim.log

# Compile the RTL and testbench from the file list
verilator --binary --timing -Wno-fatal -f vlog.f \
    --top-module tb_pe_array -Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Run and keep the transcript
"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict comes from the transcript
if grep -qx "TESTS PASSED" "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1
